// ==== src/rctl_pkg.sv ====
// register controller shared types
package rctl_pkg;

  localparam int DATA_W = 8;  // spi word width
  localparam int ADDR_W = 7;  // register address bits in a command

  // command byte, msb first on the wire
  typedef struct packed {
    logic              rw;    // 1 = write
    logic [ADDR_W-1:0] addr;  // target register
  } spi_cmd_t;

  // one received word, two decodes
  typedef union packed {
    spi_cmd_t          cmd;  // first byte of a frame
    logic [DATA_W-1:0] raw;  // data byte
  } spi_word_u;

  // frame sequencing
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for first sclk fall
    ST_CMD   = 2'd1,  // shifting command byte
    ST_DATA  = 2'd2,  // shifting data byte
    ST_DRAIN = 2'd3   // extra bytes ignored
  } fsm_state_t;

endpackage

// ==== src/spi_word_if.sv ====
// spi word level bus
`timescale 1ns/1ns

interface spi_word_if import rctl_pkg::*; ();

  logic              selected;     // frame active
  logic              bit_valid;    // one mosi bit shifted in
  logic              frame_start;  // first sclk fall of a frame
  spi_word_u         rx_word;      // receive shift register
  logic [DATA_W-1:0] tx_word;      // word presented on miso

  // front end, owns the shift logic
  modport fe (
    output selected,
    output bit_valid,
    output frame_start,
    output rx_word,
    input  tx_word
  );

  // bit counter, watches the bit stream only
  modport cnt (
    input selected,
    input bit_valid
  );

  // frame controller
  modport ctl (
    input  selected,
    input  frame_start,
    input  rx_word,
    output tx_word
  );

endinterface

// ==== src/spi_fe.sv ====
// spi mode 3 front end
`timescale 1ns/1ns

module spi_fe import rctl_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   sclk,  // serial clock idling high
  input  logic   ss,    // active low slave select
  input  logic   mosi,  // sampled on sclk rise
  output logic   miso,  // launched on sclk fall
  spi_word_if.fe bus
);

  localparam logic [DATA_W-1:0] MASK_MSB = {1'b1, {(DATA_W-1){1'b0}}};

  logic [2:0]        sclk_hist;      // sclk sampler with [2] oldest
  logic [1:0]        ss_sync;        // ss two flop sync
  logic              ss_hold;        // ss seen at sclk falls and high while idle
  logic              sclk_rise;
  logic              sclk_fall;
  logic              first_fall;     // ss low with no fall seen yet
  logic              bit_valid_q;
  logic              frame_start_q;
  logic [DATA_W-1:0] shift_rx;       // mosi shift register
  logic [DATA_W-1:0] tx_mask;        // one-hot miso bit select

  assign sclk_rise  = ~sclk_hist[2] & sclk_hist[1];         // posedge detect
  assign sclk_fall  = sclk_hist[2] & ~sclk_hist[1];         // negedge detect
  assign first_fall = ss_hold & ~ss_sync[1] & sclk_fall;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_hist <= 3'b111;  // mode 3 idle level
      ss_sync   <= 2'b11;
    end else begin
      sclk_hist <= {sclk_hist[1:0], sclk};
      ss_sync   <= {ss_sync[0], ss};
    end
  end

  // ss taken on sclk falls and forced high once ss deasserts
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ss_hold <= 1'b1;
    end else if (ss_sync[1] || sclk_fall) begin
      ss_hold <= ss_sync[1];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_valid_q   <= 1'b0;
      frame_start_q <= 1'b0;
    end else begin
      bit_valid_q   <= sclk_rise & ~ss_hold;  // lines up with shift_rx update
      frame_start_q <= first_fall;
    end
  end

  always_ff @(posedge clk) begin
    if (sclk_rise && !ss_hold) begin
      shift_rx <= {shift_rx[DATA_W-2:0], mosi};  // msb first
    end
  end

  // rotate right per fall but keep msb at the first fall
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_mask <= MASK_MSB;
    end else if (ss_hold) begin
      tx_mask <= MASK_MSB;  // idle and first fall
    end else if (sclk_fall) begin
      tx_mask <= {tx_mask[0], tx_mask[DATA_W-1:1]};
    end
  end

  assign bus.selected    = ~ss_hold;
  assign bus.bit_valid   = bit_valid_q;
  assign bus.frame_start = frame_start_q;
  assign bus.rx_word     = shift_rx;          // both views share the bits
  assign miso            = |(tx_mask & bus.tx_word);

endmodule

// ==== src/bit_counter.sv ====
// spi bit counter
`timescale 1ns/1ns

module bit_counter import rctl_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  spi_word_if.cnt bus,
  output logic    word_done  // one cycle after last bit_valid of a word
);

  localparam int CNT_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_W - 1);

  logic [CNT_W-1:0] bit_cnt;  // bits of current word

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt   <= '0;
      word_done <= 1'b0;
    end else begin
      word_done <= 1'b0;  // pulse only
      if (!bus.selected) begin
        bit_cnt <= '0;    // frame over, realign
      end else if (bus.bit_valid) begin
        if (bit_cnt == LAST_BIT) begin
          bit_cnt   <= '0;
          word_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/frame_fsm.sv ====
// spi frame controller
`timescale 1ns/1ns

module frame_fsm import rctl_pkg::*; #(
  parameter int NUM_REGS = 16
) (
  input  logic              clk,
  input  logic              rst,
  spi_word_if.ctl           bus,
  input  logic              word_done,  // a full byte is in rx_word
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [DATA_W-1:0] rd_data,
  output logic              wr_en,      // single cycle write
  output logic [ADDR_W-1:0] wr_addr,
  output logic [DATA_W-1:0] wr_data
);

  localparam logic [ADDR_W:0] REG_LIMIT = (ADDR_W+1)'(NUM_REGS);

  fsm_state_t state;
  spi_cmd_t   cmd_q;     // latched command byte
  logic       load_rd;   // rd_data valid for latched address
  logic       addr_ok;   // latched address maps to a register

  assign rd_addr = cmd_q.addr;
  assign addr_ok = {1'b0, cmd_q.addr} < REG_LIMIT;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= ST_IDLE;
      cmd_q       <= '0;
      load_rd     <= 1'b0;
      wr_en       <= 1'b0;
      bus.tx_word <= '0;
    end else begin
      wr_en   <= 1'b0;
      load_rd <= 1'b0;
      if (!bus.selected) begin
        state       <= ST_IDLE;  // ss high aborts anywhere
        bus.tx_word <= '0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (bus.frame_start) begin
              state <= ST_CMD;
            end
          end
          ST_CMD: begin
            if (word_done) begin
              cmd_q   <= bus.rx_word.cmd;
              load_rd <= ~bus.rx_word.cmd.rw;  // fetch next cycle
              state   <= ST_DATA;
            end
          end
          ST_DATA: begin
            if (word_done) begin
              wr_en       <= cmd_q.rw & addr_ok;  // out of range dropped
              bus.tx_word <= '0;                  // zeros after data byte
              state       <= ST_DRAIN;
            end
          end
          ST_DRAIN: begin
            state <= ST_DRAIN;  // wait for ss high
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
        if (load_rd) begin
          bus.tx_word <= rd_data;  // before first fall of byte 2
        end
      end
    end
  end

  // write report payload
  always_ff @(posedge clk) begin
    if (state == ST_DATA && word_done) begin
      wr_addr <= cmd_q.addr;
      wr_data <= bus.rx_word.raw;
    end
  end

endmodule

// ==== src/reg_file.sv ====
// spi register file
`timescale 1ns/1ns

module reg_file import rctl_pkg::*; #(
  parameter int NUM_REGS = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data  // combinational
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  localparam logic [ADDR_W:0] REG_LIMIT = (ADDR_W+1)'(NUM_REGS);

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic              wr_ok;  // write address in range
  logic              rd_ok;  // read address in range

  assign wr_ok = {1'b0, wr_addr} < REG_LIMIT;
  assign rd_ok = {1'b0, rd_addr} < REG_LIMIT;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // unwritten regs read zero
      end
    end else if (wr_en && wr_ok) begin
      regs[wr_addr[IDX_W-1:0]] <= wr_data;
    end
  end

  // unmapped addresses read as zero
  always_comb begin
    rd_data = '0;
    if (rd_ok) begin
      rd_data = regs[rd_addr[IDX_W-1:0]];
    end
  end

endmodule

// ==== src/spi_regctl.sv ====
// spi slave register controller
`timescale 1ns/1ns

module spi_regctl import rctl_pkg::*; #(
  parameter int NUM_REGS = 16  // up to 128
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              sclk,       // spi mode 3
  input  logic              ss,         // active low
  input  logic              mosi,
  output logic              miso,
  output logic              wr_strobe,  // one cycle per accepted write
  output logic [ADDR_W-1:0] wr_addr,    // valid with wr_strobe
  output logic [DATA_W-1:0] wr_data     // valid with wr_strobe
);

  logic              word_done;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  spi_word_if u_bus ();

  spi_fe u_spi_fe (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .ss   (ss),
    .mosi (mosi),
    .miso (miso),
    .bus  (u_bus.fe)
  );

  bit_counter u_bit_counter (
    .clk       (clk),
    .rst       (rst),
    .bus       (u_bus.cnt),
    .word_done (word_done)
  );

  frame_fsm #(
    .NUM_REGS (NUM_REGS)
  ) u_frame_fsm (
    .clk       (clk),
    .rst       (rst),
    .bus       (u_bus.ctl),
    .word_done (word_done),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .wr_en     (wr_strobe),  // write port doubles as report
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_strobe),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== sim/tb_checks.svh ====
// reference model and compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  logic [DATA_W-1:0] model_regs [NUM_REGS];  // expected register contents

  function automatic spi_word_u make_word(input int value);
    spi_word_u w;
    w.raw = value[DATA_W-1:0];  // low byte only
    return w;
  endfunction

  function automatic spi_word_u make_cmd(input bit rw, input int addr);
    spi_word_u w;
    w.cmd.rw   = rw;                // 1 = write
    w.cmd.addr = addr[ADDR_W-1:0];  // unmapped values kept as sent
    return w;
  endfunction

  function automatic void reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;  // matches register reset
    end
  endfunction

  // byte two on miso for one frame, model updated on a mapped write
  function automatic spi_word_u model_frame(input spi_word_u cmd, input spi_word_u data,
                                            output bit wr_hit);
    spi_word_u rd;
    int        idx;
    rd.raw = '0;  // writes and unmapped reads give zeros
    wr_hit = 1'b0;
    idx    = int'(cmd.cmd.addr);
    if (idx < NUM_REGS) begin
      if (cmd.cmd.rw) begin
        model_regs[idx] = data.raw;
        wr_hit          = 1'b1;  // one strobe expected
      end else begin
        rd.raw = model_regs[idx];
      end
    end
    return rd;
  endfunction

  task automatic check_byte(input string name, input spi_word_u got, input spi_word_u exp);
    if (got.raw !== exp.raw) begin
      $display("FAILED at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got.raw, exp.raw);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

`endif

// ==== sim/tb_spi_regctl.sv ====
// spi register controller testbench
`timescale 1ns/1ns

module tb_spi_regctl import rctl_pkg::*; ();

  localparam int NUM_REGS     = 16;
  localparam int HALF_CLKS    = 16;  // sclk half period in clk cycles
  localparam int GAP_CLKS     = 24;  // ss high between frames
  localparam int FRAME_COUNT  = 50;  // two byte frames in the run with long ones counted twice
  localparam int TIMEOUT_CLKS = FRAME_COUNT * 16 * 2 * HALF_CLKS + FRAME_COUNT * 64 + 200;

  logic              clk = 1'b0;
  logic              rst;
  logic              sclk;
  logic              ss;
  logic              mosi;
  logic              miso;
  logic              wr_strobe;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;

  int                seed      = 10;
  int                cycle_cnt = 0;
  logic [ADDR_W-1:0] exp_wr_addr [$];  // pending write reports with the oldest first
  spi_word_u         exp_wr_data [$];

  spi_regctl #(
    .NUM_REGS (NUM_REGS)
  ) u_spi_regctl (
    .clk       (clk),
    .rst       (rst),
    .sclk      (sclk),
    .ss        (ss),
    .mosi      (mosi),
    .miso      (miso),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  always #2 clk = ~clk;  // 4 ns period

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_checks.svh"

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one mode 3 byte sent msb first with miso taken at each rise
  task automatic shift_byte(input spi_word_u tx, output spi_word_u rx);
    for (int i = DATA_W - 1; i >= 0; i--) begin
      sclk = 1'b0;  // launch edge
      mosi = tx.raw[i];
      wait_clks(HALF_CLKS);
      rx.raw[i] = miso;  // settled since the fall
      sclk      = 1'b1;  // sample edge
      wait_clks(HALF_CLKS);
    end
  endtask

  task automatic spi_frame(input spi_word_u cmd, input spi_word_u data,
                           input int n_extra, input bit abort_after_cmd);
    spi_word_u rx;
    spi_word_u rd_exp;
    spi_word_u filler;
    bit        wr_hit;
    int        rnd;
    rd_exp.raw = '0;
    wr_hit     = 1'b0;
    if (!abort_after_cmd) begin
      rd_exp = model_frame(cmd, data, wr_hit);
    end
    if (wr_hit) begin
      exp_wr_addr.push_back(cmd.cmd.addr);
      exp_wr_data.push_back(data);
    end
    ss = 1'b0;
    wait_clks(HALF_CLKS / 2);
    shift_byte(cmd, rx);
    check_byte("miso", rx, make_word(0));  // nothing to send yet
    if (!abort_after_cmd) begin
      shift_byte(data, rx);
      check_byte("miso", rx, rd_exp);
      for (int k = 0; k < n_extra; k++) begin
        rnd    = $random(seed);
        filler = make_cmd(1'b1, rnd);  // looks like a write command
        shift_byte(filler, rx);
        check_byte("miso", rx, make_word(0));
      end
    end
    ss = 1'b1;
    wait_clks(GAP_CLKS);
    if (exp_wr_addr.size() != 0) begin
      $display("write strobe missing for frame with command 0x%02h", cmd.raw);
      abort_run();
    end
  endtask

  // every strobe against the oldest pending write
  always @(negedge clk) begin : wr_monitor
    spi_word_u         got_w;
    spi_word_u         exp_w;
    logic [ADDR_W-1:0] exp_a;
    if (!rst && wr_strobe) begin
      if (exp_wr_addr.size() == 0) begin
        $display("unexpected write strobe at %0t ns to address 0x%02h", $time, wr_addr);
        abort_run();
      end else begin
        exp_a     = exp_wr_addr.pop_front();
        exp_w     = exp_wr_data.pop_front();
        got_w.raw = wr_data;
        check_addr("wr_addr", wr_addr, exp_a);
        check_byte("wr_data", got_w, exp_w);
      end
    end
  end

  always @(posedge clk) begin : watchdog
    fsm_state_t st;
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CLKS) begin
      st = u_spi_regctl.u_frame_fsm.state;
      $display("run did not finish within %0d clock cycles, frame FSM in %s",
               cycle_cnt, st.name());
      abort_run();
    end
  end

  initial begin : main_seq
    int rnd;
    int addr;
    rst  = 1'b1;
    sclk = 1'b1;  // mode 3 idle
    ss   = 1'b1;
    mosi = 1'b0;
    reset_model();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    repeat (20) begin  // deselected slave keeps miso low
      @(negedge clk);
      check_bit("miso", miso, 1'b0);
    end
    spi_frame(make_cmd(1'b1, 5), make_word('hA5), 0, 1'b0);  // write then read back
    spi_frame(make_cmd(1'b0, 5), make_word(0), 0, 1'b0);
    for (int k = 0; k < 20; k++) begin  // random fill
      rnd  = $random(seed);
      addr = (rnd & 32'h7fff_ffff) % NUM_REGS;
      rnd  = $random(seed);
      spi_frame(make_cmd(1'b1, addr), make_word(rnd), 0, 1'b0);
    end
    for (int k = 0; k < NUM_REGS; k++) begin  // full readback
      spi_frame(make_cmd(1'b0, k), make_word(0), 0, 1'b0);
    end
    spi_frame(make_cmd(1'b1, NUM_REGS), make_word('h3C), 0, 1'b0);  // unmapped
    spi_frame(make_cmd(1'b1, 127), make_word('hFF), 0, 1'b0);
    spi_frame(make_cmd(1'b0, NUM_REGS), make_word(0), 0, 1'b0);
    spi_frame(make_cmd(1'b0, 127), make_word(0), 0, 1'b0);
    spi_frame(make_cmd(1'b1, 3), make_word('h5A), 2, 1'b0);  // trailing bytes
    spi_frame(make_cmd(1'b0, 3), make_word(0), 0, 1'b0);
    spi_frame(make_cmd(1'b1, 9), make_word('h77), 0, 1'b1);  // ss up after command
    spi_frame(make_cmd(1'b0, 9), make_word(0), 0, 1'b0);
    spi_frame(make_cmd(1'b1, 9), make_word('h81), 0, 1'b0);
    spi_frame(make_cmd(1'b0, 9), make_word(0), 0, 1'b0);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
src/rctl_pkg.sv
src/spi_word_if.sv
src/spi_fe.sv
src/bit_counter.sv
src/frame_fsm.sv
src/reg_file.sv
src/spi_regctl.sv
sim/tb_spi_regctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_spi_regctl
FILELIST  := tb.f

SRCS := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulator is the result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
